// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [15:0] imm16_t;
    typedef logic [7:0]  imm8_t;

    typedef enum logic [3:0] {
        R0, R1, R2, R3, R4, R5, R6, R7,
        R8, R9, R10, R11, SP, LR, STATUS, PC
    } reg_e;

    typedef enum logic [3:0] {
        NONE, EQ, NE, LTU, GTU, LEU, GEU, LTS, GTS, LES, GES
    } cond_e;

    // 8'hf0 to 8'hff are alu ops, low nibble is the alu_op_e
    typedef enum logic [7:0] {
        NOP  = 8'h00,
        LD   = 8'h01,
        LDR  = 8'h02,
        LDI  = 8'h03,
        ST   = 8'h04,
        STR  = 8'h05,
        PUSH = 8'h06,
        POP  = 8'h07,
        INT  = 8'h08
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SHL, SHR, PASS
    } alu_op_e;

    typedef enum logic {
        USER,
        SUPERVISOR
    } cpu_mode_e;

    // bus masks
    typedef enum logic [1:0] {
        MASK_FULL,
        MASK_16,
        MASK_8
    } mask_e;

    typedef struct packed {
        logic negative;
        logic zero;
        logic carry;
        logic overflow;
    } alu_flags_t;

    typedef struct packed {
        cpu_mode_e  mode;
        logic       imask;
        alu_flags_t flags;
    } status_t;

    typedef struct packed {
        logic immediate;
        logic reverse;
        logic loadn;
        logic set_status;
    } alu_mode_t;

    // LD, LDI, ST
    typedef struct packed {
        reg_e   reg_a;
        imm16_t imm16;
    } imm_params_t;

    // register forms, also LDR, STR, PUSH, POP
    typedef struct packed {
        reg_e       reg_a;
        reg_e       reg_b;
        reg_e       reg_c;
        logic [3:0] rsvd;
        alu_mode_t  mode;
    } rr_params_t;

    typedef struct packed {
        reg_e      reg_a;
        reg_e      reg_b;
        imm8_t     imm8;
        alu_mode_t mode;
    } ri_params_t;

    typedef union packed {
        imm_params_t imm;
        rr_params_t  rr;
        ri_params_t  ri;
    } params_t;

    typedef struct packed {
        cond_e   cond;
        opcode_e opcode;
        params_t params;
    } ir_t;

    typedef struct packed {
        logic      oe_alu;
        alu_op_e   alu_op;
        reg_e      sel_a;
        reg_e      sel_b;
        reg_e      sel_in;
        logic      oe_a_reg;
        logic      oe_b_reg;
        logic      ld_reg;
        mask_e     a_mask_sel;
        mask_e     b_mask_sel;
        logic      ld_pc_lr;
        logic      post_inc_sp;
        logic      pre_dec_sp;
        logic      post_inc_pc;
        logic      oe_a_ir;
        logic      oe_b_ir;
        logic      oe_b_consts;
        logic      ld_ir;
        logic      ld_alu_status;
        logic      imask_in;
        logic      ld_imask;
        cpu_mode_e mode_in;
        logic      ld_mode;
    } ctrl_t;

    localparam word_t HWINT_VEC  = 32'd1;
    localparam word_t SWINT_VEC  = 32'd2;
    localparam word_t EXCEPT_VEC = 32'd3;

endpackage

`default_nettype wire

// File: alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  alu_op_e    op,
    input  word_t      a,
    input  word_t      b,
    output word_t      result,
    output alu_flags_t flags
);

    // bit 32 carries the carry flag
    logic [32:0] wide;
    logic [32:0] shr;
    logic        ovf;

    always_comb begin
        wide = '0;
        ovf = 1'b0;
        shr = {a, 1'b0} >> b[4:0];
        case (op)
            ADD: begin
                wide = {1'b0, a} + {1'b0, b};
                ovf = (a[31] == b[31]) && (wide[31] != a[31]);
            end
            SUB: begin
                wide = {1'b0, a} - {1'b0, b};
                // carry set means no borrow
                wide[32] = ~wide[32];
                ovf = (a[31] != b[31]) && (wide[31] != a[31]);
            end
            AND: wide = {1'b0, a & b};
            OR: wide = {1'b0, a | b};
            XOR: wide = {1'b0, a ^ b};
            SHL: wide = {1'b0, a} << b[4:0];
            // last bit shifted out lands in carry
            SHR: wide = {shr[0], shr[32:1]};
            default: wide = {1'b0, b};
        endcase

        result = wide[31:0];
        flags.negative = wide[31];
        flags.zero = (wide[31:0] == '0);
        flags.carry = wide[32];
        flags.overflow = ovf;
    end

endmodule

`default_nettype wire

// File: datapath.sv
`timescale 1ns/10ps
`default_nettype none

module datapath import cpu_pkg::*; #(
    parameter word_t STACK_TOP = 32'h100
) (
    input  logic    clk,
    input  logic    rst,
    input  ctrl_t   ctrl,
    input  word_t   mem_rdata,
    output word_t   mem_addr,
    output word_t   mem_wdata,
    output ir_t     ir,
    output status_t status
);

    word_t      gpr [12];
    word_t      lr;
    word_t      sp;
    word_t      pc;
    status_t    status_q;
    ir_t        ir_q;

    word_t      a_bus;
    word_t      b_bus;
    word_t      alu_result;
    alu_flags_t alu_flags;
    word_t      wb;
    logic       ld_gpr;

    function automatic word_t read_reg(input reg_e r);
        case (r)
            // push addresses the slot below SP in the same cycle
            SP: read_reg = ctrl.pre_dec_sp ? sp - 32'd1 : sp;
            LR: read_reg = lr;
            STATUS: read_reg = {{(32 - $bits(status_t)){1'b0}}, status_q};
            PC: read_reg = pc;
            default: read_reg = gpr[r];
        endcase
    endfunction

    // imm8 for the 8-bit mask, imm16 otherwise
    function automatic word_t ir_operand(input mask_e m);
        if (m == MASK_8) begin
            ir_operand = {24'b0, ir_q.params.ri.imm8};
        end else begin
            ir_operand = {16'b0, ir_q.params.imm.imm16};
        end
    endfunction

    function automatic word_t mask_of(input mask_e m);
        case (m)
            MASK_16: mask_of = 32'h0000_ffff;
            MASK_8: mask_of = 32'h0000_00ff;
            default: mask_of = 32'hffff_ffff;
        endcase
    endfunction

    always_comb begin
        a_bus = '0;
        if (ctrl.oe_a_reg) begin
            a_bus = read_reg(ctrl.sel_a);
        end else if (ctrl.oe_a_ir) begin
            a_bus = ir_operand(ctrl.a_mask_sel);
        end
        a_bus = a_bus & mask_of(ctrl.a_mask_sel);
    end

    always_comb begin
        b_bus = '0;
        if (ctrl.oe_b_reg) begin
            b_bus = read_reg(ctrl.sel_b);
        end else if (ctrl.oe_b_ir) begin
            b_bus = ir_operand(ctrl.b_mask_sel);
        end else if (ctrl.oe_b_consts) begin
            // vector number rides on sel_b
            b_bus = {28'b0, ctrl.sel_b};
        end
        b_bus = b_bus & mask_of(ctrl.b_mask_sel);
    end

    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (a_bus),
        .b      (b_bus),
        .result (alu_result),
        .flags  (alu_flags)
    );

    assign wb = ctrl.oe_alu ? alu_result : mem_rdata;
    assign ld_gpr = ctrl.ld_reg && (ctrl.sel_in < SP);

    assign mem_addr = b_bus;
    assign mem_wdata = a_bus;
    assign status = status_q;
    // cu decodes the word while it is being fetched
    assign ir = ctrl.ld_ir ? ir_t'(mem_rdata) : ir_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            sp <= STACK_TOP;
            status_q <= '{mode: SUPERVISOR, imask: 1'b0, flags: '0};
        end else begin
            if (ctrl.ld_reg && ctrl.sel_in == PC) begin
                pc <= wb;
            end else if (ctrl.post_inc_pc) begin
                pc <= pc + 32'd1;
            end

            if (ctrl.ld_reg && ctrl.sel_in == SP) begin
                sp <= wb;
            end else if (ctrl.pre_dec_sp) begin
                sp <= sp - 32'd1;
            end else if (ctrl.post_inc_sp) begin
                sp <= sp + 32'd1;
            end

            if (ctrl.ld_reg && ctrl.sel_in == STATUS) begin
                status_q <= status_t'(wb[$bits(status_t)-1:0]);
            end else begin
                if (ctrl.ld_alu_status) begin
                    status_q.flags <= alu_flags;
                end
                if (ctrl.ld_imask) begin
                    status_q.imask <= ctrl.imask_in;
                end
                if (ctrl.ld_mode) begin
                    status_q.mode <= ctrl.mode_in;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ld_ir) begin
            ir_q <= ir_t'(mem_rdata);
        end
        if (ld_gpr) begin
            gpr[ctrl.sel_in] <= wb;
        end
        // return address for jumps through PC
        if (ctrl.ld_pc_lr) begin
            lr <= pc;
        end else if (ctrl.ld_reg && ctrl.sel_in == LR) begin
            lr <= wb;
        end
    end

endmodule

`default_nettype wire

// File: cu.sv
`timescale 1ns/10ps
`default_nettype none

module cu import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  logic    hwint,
    input  ir_t     ir,
    input  status_t status,
    output ctrl_t   ctrl,
    output logic    mem_rd,
    output logic    mem_wr
);

    typedef enum logic [4:0] {
        STOP,
        FETCH,
        NOP_EX,
        LD_EX,
        LDR_EX,
        LDI_EX,
        ST_EX,
        STR_EX,
        PUSH_EX,
        POP_EX,
        ALU_EX,
        HWINT1,
        HWINT2,
        SWINT1,
        SWINT2,
        EXCEPT1,
        EXCEPT2
    } state_e;

    state_e state;
    state_e decode_next;
    ir_t    ir_ex;
    logic   priv_fault;

    function automatic logic cond_ok(input cond_e c, input alu_flags_t f);
        case (c)
            EQ: cond_ok = f.zero;
            NE: cond_ok = !f.zero;
            LTU: cond_ok = !f.carry;
            GTU: cond_ok = f.carry && !f.zero;
            LEU: cond_ok = !f.carry || f.zero;
            GEU: cond_ok = f.carry;
            LTS: cond_ok = f.negative != f.overflow;
            GTS: cond_ok = !f.zero && (f.negative == f.overflow);
            LES: cond_ok = f.zero || (f.negative != f.overflow);
            GES: cond_ok = f.negative == f.overflow;
            default: cond_ok = 1'b1;
        endcase
    endfunction

    // reg_a is bits 19:16 in every format
    assign priv_fault = (ir.params.imm.reg_a == STATUS) && (status.mode == USER);

    always_comb begin
        decode_next = EXCEPT1;
        if (hwint && status.imask) begin
            decode_next = HWINT1;
        end else if (!cond_ok(ir.cond, status.flags)) begin
            decode_next = FETCH;
        end else begin
            casez (ir.opcode)
                NOP: decode_next = NOP_EX;
                LD: decode_next = priv_fault ? EXCEPT1 : LD_EX;
                LDR: decode_next = priv_fault ? EXCEPT1 : LDR_EX;
                LDI: decode_next = priv_fault ? EXCEPT1 : LDI_EX;
                ST: decode_next = ST_EX;
                STR: decode_next = STR_EX;
                PUSH: decode_next = PUSH_EX;
                POP: decode_next = priv_fault ? EXCEPT1 : POP_EX;
                INT: decode_next = SWINT1;
                8'hf?: decode_next = priv_fault ? EXCEPT1 : ALU_EX;
                default: decode_next = EXCEPT1;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= STOP;
        end else begin
            case (state)
                STOP: state <= start ? FETCH : STOP;
                FETCH: state <= decode_next;
                HWINT1: state <= HWINT2;
                SWINT1: state <= SWINT2;
                EXCEPT1: state <= EXCEPT2;
                default: state <= FETCH;
            endcase
        end
    end

    // executing instruction, latched as it is fetched
    always_ff @(posedge clk) begin
        if (state == FETCH) begin
            ir_ex <= ir;
        end
    end

    always_comb begin
        ctrl = '0;
        mem_rd = 1'b0;
        mem_wr = 1'b0;

        case (state)
            // ir <- mem[pc++]
            FETCH: begin
                ctrl.sel_b = PC;
                ctrl.oe_b_reg = 1'b1;
                ctrl.ld_ir = 1'b1;
                ctrl.post_inc_pc = 1'b1;
                mem_rd = 1'b1;
            end
            LD_EX: begin
                ctrl.oe_b_ir = 1'b1;
                ctrl.b_mask_sel = MASK_16;
                ctrl.sel_in = ir_ex.params.imm.reg_a;
                ctrl.ld_reg = 1'b1;
                mem_rd = 1'b1;
            end
            LDR_EX: begin
                ctrl.sel_b = ir_ex.params.rr.reg_b;
                ctrl.oe_b_reg = 1'b1;
                ctrl.sel_in = ir_ex.params.rr.reg_a;
                ctrl.ld_reg = 1'b1;
                mem_rd = 1'b1;
            end
            LDI_EX: begin
                ctrl.oe_b_ir = 1'b1;
                ctrl.b_mask_sel = MASK_16;
                ctrl.alu_op = PASS;
                ctrl.oe_alu = 1'b1;
                ctrl.sel_in = ir_ex.params.imm.reg_a;
                ctrl.ld_reg = 1'b1;
            end
            ST_EX: begin
                ctrl.sel_a = ir_ex.params.imm.reg_a;
                ctrl.oe_a_reg = 1'b1;
                ctrl.oe_b_ir = 1'b1;
                ctrl.b_mask_sel = MASK_16;
                mem_wr = 1'b1;
            end
            STR_EX: begin
                ctrl.sel_a = ir_ex.params.rr.reg_a;
                ctrl.oe_a_reg = 1'b1;
                ctrl.sel_b = ir_ex.params.rr.reg_b;
                ctrl.oe_b_reg = 1'b1;
                mem_wr = 1'b1;
            end
            // mem[--sp] <- reg_a
            PUSH_EX: begin
                ctrl.pre_dec_sp = 1'b1;
                ctrl.sel_a = ir_ex.params.rr.reg_a;
                ctrl.oe_a_reg = 1'b1;
                ctrl.sel_b = SP;
                ctrl.oe_b_reg = 1'b1;
                mem_wr = 1'b1;
            end
            // reg_a <- mem[sp++]
            POP_EX: begin
                ctrl.post_inc_sp = 1'b1;
                ctrl.sel_b = SP;
                ctrl.oe_b_reg = 1'b1;
                ctrl.sel_in = ir_ex.params.rr.reg_a;
                ctrl.ld_reg = 1'b1;
                mem_rd = 1'b1;
            end
            ALU_EX: begin
                if (ir_ex.params.ri.mode.immediate) begin
                    if (ir_ex.params.ri.mode.reverse) begin
                        ctrl.oe_a_ir = 1'b1;
                        ctrl.a_mask_sel = MASK_8;
                        ctrl.sel_b = ir_ex.params.ri.reg_b;
                        ctrl.oe_b_reg = 1'b1;
                    end else begin
                        ctrl.sel_a = ir_ex.params.ri.reg_b;
                        ctrl.oe_a_reg = 1'b1;
                        ctrl.oe_b_ir = 1'b1;
                        ctrl.b_mask_sel = MASK_8;
                    end
                end else begin
                    if (ir_ex.params.rr.mode.reverse) begin
                        ctrl.sel_a = ir_ex.params.rr.reg_c;
                        ctrl.sel_b = ir_ex.params.rr.reg_b;
                    end else begin
                        ctrl.sel_a = ir_ex.params.rr.reg_b;
                        ctrl.sel_b = ir_ex.params.rr.reg_c;
                    end
                    ctrl.oe_a_reg = 1'b1;
                    ctrl.oe_b_reg = 1'b1;
                end
                ctrl.alu_op = alu_op_e'(ir_ex.opcode[3:0]);
                ctrl.oe_alu = !ir_ex.params.rr.mode.loadn;
                ctrl.sel_in = ir_ex.params.rr.reg_a;
                ctrl.ld_reg = !ir_ex.params.rr.mode.loadn;
                ctrl.ld_alu_status = ir_ex.params.rr.mode.set_status;
            end
            // save return pc below sp
            HWINT1, SWINT1, EXCEPT1: begin
                ctrl.pre_dec_sp = 1'b1;
                ctrl.sel_a = PC;
                ctrl.oe_a_reg = 1'b1;
                ctrl.sel_b = SP;
                ctrl.oe_b_reg = 1'b1;
                mem_wr = 1'b1;
            end
            // pc <- vector, supervisor mode
            HWINT2, SWINT2, EXCEPT2: begin
                if (state == HWINT2) begin
                    ctrl.sel_b = reg_e'(HWINT_VEC[3:0]);
                end else if (state == SWINT2) begin
                    ctrl.sel_b = reg_e'(SWINT_VEC[3:0]);
                end else begin
                    ctrl.sel_b = reg_e'(EXCEPT_VEC[3:0]);
                end
                ctrl.oe_b_consts = 1'b1;
                ctrl.alu_op = PASS;
                ctrl.oe_alu = 1'b1;
                ctrl.sel_in = PC;
                ctrl.ld_reg = 1'b1;
                ctrl.imask_in = 1'b0;
                ctrl.ld_imask = (state != EXCEPT2);
                ctrl.mode_in = SUPERVISOR;
                ctrl.ld_mode = 1'b1;
            end
            default: ;
        endcase

        // jumps keep a return address, vector loads do not
        ctrl.ld_pc_lr = ctrl.ld_reg && (ctrl.sel_in == PC) && !ctrl.ld_mode;
    end

endmodule

`default_nettype wire

// File: cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter word_t STACK_TOP = 32'h100
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  logic  hwint,
    input  word_t mem_rdata,
    output logic  mem_rd,
    output logic  mem_wr,
    output word_t mem_addr,
    output word_t mem_wdata
);

    ctrl_t   ctrl;
    ir_t     ir;
    status_t status;

    cu u_cu (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .hwint  (hwint),
        .ir     (ir),
        .status (status),
        .ctrl   (ctrl),
        .mem_rd (mem_rd),
        .mem_wr (mem_wr)
    );

    datapath #(
        .STACK_TOP (STACK_TOP)
    ) u_datapath (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .ir        (ir),
        .status    (status)
    );

endmodule

`default_nettype wire

// File: cpu_assert.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_assert (
    input logic clk,
    input logic rst,
    input logic start,
    input logic mem_rd,
    input logic mem_wr
);

    logic started;

    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
        end else if (start) begin
            started <= 1'b1;
        end
    end

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst) !(mem_rd && mem_wr))
        else $error("memory read and write strobes high together");

    quiet_after_reset: assert property (@(posedge clk) rst |=> (!mem_rd && !mem_wr))
        else $error("memory strobe active in the cycle after reset");

    write_after_start: assert property (@(posedge clk) disable iff (rst) mem_wr |-> started)
        else $error("memory write before the start pulse");

endmodule

bind cpu_top cpu_assert u_cpu_assert (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .mem_rd (mem_rd),
    .mem_wr (mem_wr)
);

`default_nettype wire

// File: tb_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

    localparam word_t STACK_TOP = 32'h100;
    localparam int RESET_CYCLES = 8;
    // six runs of under 150 cycles each, with a wide margin
    localparam int MAX_CYCLES = 4000;
    localparam int MARK_WAIT = 500;
    localparam int DATA_BASE = 'h180;
    localparam int RES_BASE = 'h200;
    localparam int MARK_ADDR = 'h3ff;

    // alu mode nibble: immediate, reverse, loadn, set_status
    localparam logic [3:0] M_IMM = 4'b1000;
    localparam logic [3:0] M_REV = 4'b0100;
    localparam logic [3:0] M_NLD = 4'b0010;
    localparam logic [3:0] M_SET = 4'b0001;

    logic  clk;
    logic  rst;
    logic  start;
    logic  hwint;
    logic  load_req;
    logic  mem_rd;
    logic  mem_wr;
    word_t mem_rdata;
    word_t mem_addr;
    word_t mem_wdata;

    word_t mem [1024];
    word_t image [1024];
    int    next_addr;
    int    seed = 32'h84e8a79e;
    int    mismatches = 0;
    int    failures = 0;
    int    cycles;

    cpu_top #(
        .STACK_TOP (STACK_TOP)
    ) DUT (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .hwint     (hwint),
        .mem_rdata (mem_rdata),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // memory model, image copied in while the core sits in reset
    // read data only valid under mem_rd
    assign mem_rdata = mem_rd ? mem[mem_addr[9:0]] : '0;

    always @(posedge clk) begin
        if (load_req) begin
            for (int i = 0; i < 1024; i++) begin
                mem[i] <= image[i];
            end
        end else if (mem_wr) begin
            mem[mem_addr[9:0]] <= mem_wdata;
        end
    end

    function automatic word_t fill_word(input int a);
        fill_word = 32'h5eed_0000 | word_t'(a & 'h3ff);
    endfunction

    function automatic word_t imm_form(input cond_e c, input opcode_e op, input reg_e ra,
                                       input imm16_t imm);
        imm_form = {c, op, ra, imm};
    endfunction

    function automatic word_t reg_form(input opcode_e op, input reg_e ra, input reg_e rb);
        reg_form = {NONE, op, ra, rb, 12'h000};
    endfunction

    function automatic word_t alu_rr(input alu_op_e f, input reg_e ra, input reg_e rb,
                                     input reg_e rc, input logic [3:0] m);
        alu_rr = {NONE, 4'hf, f, ra, rb, rc, 4'h0, m};
    endfunction

    function automatic word_t alu_ri(input alu_op_e f, input reg_e ra, input reg_e rb,
                                     input imm8_t imm, input logic [3:0] m);
        alu_ri = {NONE, 4'hf, f, ra, rb, imm, m};
    endfunction

    // expected outcome of a compare a - b
    function automatic logic cond_holds(input cond_e c, input word_t a, input word_t b);
        case (c)
            EQ: cond_holds = (a == b);
            NE: cond_holds = (a != b);
            LTU: cond_holds = (a < b);
            GES: cond_holds = ($signed(a) >= $signed(b));
            default: cond_holds = 1'b1;
        endcase
    endfunction

    task automatic clear_image();
        for (int i = 0; i < 1024; i++) begin
            image[i] = fill_word(i);
        end
        next_addr = 0;
    endtask

    task automatic emit(input word_t w);
        image[10'(next_addr)] = w;
        next_addr++;
    endtask

    task automatic put_data(input int addr, input word_t v);
        image[10'(addr)] = v;
    endtask

    task automatic halt_program();
        emit(imm_form(NONE, ST, R0, 16'(MARK_ADDR)));
        emit(imm_form(NONE, LDI, PC, 16'(next_addr)));
    endtask

    task automatic place_vectors(input int hw, input int sw, input int ex);
        next_addr = 0;
        emit(imm_form(NONE, LDI, PC, 16'h0010));
        emit(imm_form(NONE, LDI, PC, 16'(hw)));
        emit(imm_form(NONE, LDI, PC, 16'(sw)));
        emit(imm_form(NONE, LDI, PC, 16'(ex)));
        next_addr = 'h10;
    endtask

    // handler that must never run
    task automatic stray_handler();
        emit(imm_form(NONE, LDI, R2, 16'hdead));
        emit(imm_form(NONE, ST, R2, 16'(RES_BASE + 3)));
        halt_program();
    endtask

    task automatic boot(input logic irq);
        @(posedge clk);
        #1;
        rst = 1'b1;
        start = 1'b0;
        hwint = 1'b0;
        load_req = 1'b1;
        @(posedge clk);
        #1;
        load_req = 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        #1;
        rst = 1'b0;
        hwint = irq;
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_marker();
        logic seen;
        int   n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < MARK_WAIT) begin
            @(negedge clk);
            seen = mem_wr && (mem_addr == word_t'(MARK_ADDR));
            n++;
        end
        // let the marker write land
        @(posedge clk);
        #1;
        assert (seen) else begin
            $display("program never stored its end marker within %0d cycles", MARK_WAIT);
            failures++;
        end
    endtask

    task automatic expect_word(input string name, input int addr, input word_t exp);
        word_t got;
        got = mem[10'(addr)];
        assert (got === exp) else begin
            $display("MISMATCH %s mem[%0h]: got %08h, expected %08h", name, addr, got, exp);
            mismatches++;
        end
    endtask

    task automatic alu_ops_test();
        word_t  d0;
        word_t  d1;
        word_t  rnd;
        imm16_t k16;
        imm8_t  sh8;
        imm8_t  k8;
        clear_image();
        d0 = $random(seed);
        d1 = $random(seed);
        rnd = $random(seed);
        k16 = rnd[15:0];
        sh8 = rnd[23:16];
        k8 = rnd[31:24];
        put_data(DATA_BASE, d0);
        put_data(DATA_BASE + 1, d1);
        emit(imm_form(NONE, LD, R1, 16'(DATA_BASE)));
        emit(imm_form(NONE, LD, R2, 16'(DATA_BASE + 1)));
        emit(imm_form(NONE, LDI, R3, k16));
        emit(imm_form(NONE, LDI, R11, 16'h1234));
        emit(alu_rr(ADD, R4, R1, R2, 4'b0000));
        emit(alu_rr(SUB, R5, R1, R2, 4'b0000));
        emit(alu_rr(XOR, R6, R1, R2, 4'b0000));
        emit(alu_ri(SHL, R7, R1, sh8, M_IMM));
        emit(alu_rr(SUB, R8, R1, R2, M_REV));
        emit(alu_ri(SUB, R9, R3, k8, M_IMM | M_REV));
        emit(alu_ri(ADD, R10, R3, k8, M_IMM));
        emit(alu_rr(ADD, R11, R1, R2, M_NLD));
        for (int r = 1; r <= 11; r++) begin
            if (r != 2) begin
                emit(imm_form(NONE, ST, reg_e'(4'(r)), 16'(RES_BASE + r)));
            end
        end
        halt_program();
        boot(1'b0);
        wait_marker();
        expect_word("r1 ld", RES_BASE + 1, d0);
        expect_word("r3 ldi", RES_BASE + 3, {16'h0000, k16});
        expect_word("r4 add", RES_BASE + 4, d0 + d1);
        expect_word("r5 sub", RES_BASE + 5, d0 - d1);
        expect_word("r6 xor", RES_BASE + 6, d0 ^ d1);
        expect_word("r7 shl imm", RES_BASE + 7, d0 << sh8[4:0]);
        expect_word("r8 sub reverse", RES_BASE + 8, d1 - d0);
        expect_word("r9 sub reverse imm", RES_BASE + 9, {24'h0, k8} - {16'h0, k16});
        expect_word("r10 add imm", RES_BASE + 10, {16'h0, k16} + {24'h0, k8});
        expect_word("r11 loadn", RES_BASE + 11, 32'h0000_1234);
    endtask

    task automatic cond_exec_test();
        word_t pa [5];
        word_t pb [5];
        cond_e conds [4];
        int    slot;
        clear_image();
        pa = '{32'd5, 32'd3, 32'd7, 32'h8000_0000, 32'd1};
        pb = '{32'd5, 32'd7, 32'd3, 32'd1, 32'h8000_0000};
        conds = '{EQ, NE, LTU, GES};
        for (int k = 0; k < 5; k++) begin
            put_data(DATA_BASE + 2 * k, pa[k]);
            put_data(DATA_BASE + 2 * k + 1, pb[k]);
            emit(imm_form(NONE, LD, R1, 16'(DATA_BASE + 2 * k)));
            emit(imm_form(NONE, LD, R2, 16'(DATA_BASE + 2 * k + 1)));
            emit(imm_form(NONE, LDI, R3, 16'('hc000 + k)));
            // compare only, flags kept
            emit(alu_rr(SUB, R0, R1, R2, M_NLD | M_SET));
            for (int j = 0; j < 4; j++) begin
                emit(imm_form(conds[j], ST, R3, 16'(RES_BASE + 4 * k + j)));
            end
        end
        halt_program();
        boot(1'b0);
        wait_marker();
        for (int k = 0; k < 5; k++) begin
            for (int j = 0; j < 4; j++) begin
                slot = RES_BASE + 4 * k + j;
                if (cond_holds(conds[j], pa[k], pb[k])) begin
                    expect_word($sformatf("%s store %0d", conds[j].name(), k), slot,
                                word_t'('hc000 + k));
                end else begin
                    expect_word($sformatf("%s skip %0d", conds[j].name(), k), slot,
                                fill_word(slot));
                end
            end
        end
    endtask

    task automatic stack_test();
        clear_image();
        put_data(DATA_BASE, 32'h1357_9bdf);
        emit(imm_form(NONE, LDI, R1, 16'ha1a1));
        emit(imm_form(NONE, LDI, R2, 16'hb2b2));
        emit(reg_form(PUSH, R1, R0));
        emit(reg_form(PUSH, R2, R0));
        emit(reg_form(POP, R4, R0));
        emit(reg_form(POP, R5, R0));
        emit(imm_form(NONE, ST, R4, 16'(RES_BASE)));
        emit(imm_form(NONE, ST, R5, 16'(RES_BASE + 1)));
        emit(imm_form(NONE, ST, SP, 16'(RES_BASE + 2)));
        emit(imm_form(NONE, LDI, R6, 16'(RES_BASE + 8)));
        emit(imm_form(NONE, LDI, R7, 16'hc3c3));
        emit(reg_form(STR, R7, R6));
        emit(imm_form(NONE, LDI, R9, 16'(DATA_BASE)));
        emit(reg_form(LDR, R10, R9));
        emit(reg_form(LDR, R8, R6));
        emit(imm_form(NONE, ST, R10, 16'(RES_BASE + 3)));
        emit(imm_form(NONE, ST, R8, 16'(RES_BASE + 4)));
        halt_program();
        boot(1'b0);
        wait_marker();
        expect_word("push r1", int'(STACK_TOP) - 1, 32'h0000_a1a1);
        expect_word("push r2", int'(STACK_TOP) - 2, 32'h0000_b2b2);
        expect_word("pop r4", RES_BASE, 32'h0000_b2b2);
        expect_word("pop r5", RES_BASE + 1, 32'h0000_a1a1);
        expect_word("sp after pops", RES_BASE + 2, STACK_TOP);
        expect_word("str r7", RES_BASE + 8, 32'h0000_c3c3);
        expect_word("ldr r10", RES_BASE + 3, 32'h1357_9bdf);
        expect_word("ldr r8", RES_BASE + 4, 32'h0000_c3c3);
    endtask

    task automatic trap_test();
        int int_at;
        int fault_at;
        clear_image();
        place_vectors('h38, 'h20, 'h28);
        int_at = next_addr;
        emit(imm_form(NONE, INT, R0, 16'h0000));
        next_addr = 'h20;
        emit(imm_form(NONE, LDI, R1, 16'h5157));
        emit(imm_form(NONE, ST, R1, 16'(RES_BASE)));
        // drop to user mode, then touch STATUS
        emit(imm_form(NONE, LDI, STATUS, 16'h0000));
        fault_at = next_addr;
        emit(imm_form(NONE, LDI, STATUS, 16'h0030));
        next_addr = 'h28;
        emit(imm_form(NONE, ST, STATUS, 16'(RES_BASE + 1)));
        emit(imm_form(NONE, ST, SP, 16'(RES_BASE + 2)));
        halt_program();
        next_addr = 'h38;
        stray_handler();
        boot(1'b0);
        wait_marker();
        expect_word("int return pc", int'(STACK_TOP) - 1, word_t'(int_at + 1));
        expect_word("int handler store", RES_BASE, 32'h0000_5157);
        expect_word("exception return pc", int'(STACK_TOP) - 2, word_t'(fault_at + 1));
        // supervisor, imask clear, flags clear
        expect_word("status in handler", RES_BASE + 1, 32'h0000_0020);
        expect_word("sp in handler", RES_BASE + 2, STACK_TOP - 32'd2);
        expect_word("stray handler", RES_BASE + 3, fill_word(RES_BASE + 3));
    endtask

    task automatic hwint_test(input logic masked);
        int irq_at;
        clear_image();
        place_vectors('h30, 'h38, 'h38);
        emit(imm_form(NONE, LDI, STATUS, masked ? 16'h0030 : 16'h0020));
        irq_at = next_addr;
        emit(imm_form(NONE, LDI, R1, 16'h6d61));
        emit(imm_form(NONE, ST, R1, 16'(RES_BASE)));
        halt_program();
        next_addr = 'h30;
        emit(imm_form(NONE, LDI, R2, 16'h4857));
        emit(imm_form(NONE, ST, R2, 16'(RES_BASE + 1)));
        emit(imm_form(NONE, ST, STATUS, 16'(RES_BASE + 2)));
        halt_program();
        next_addr = 'h38;
        stray_handler();
        boot(1'b1);
        wait_marker();
        hwint = 1'b0;
        if (masked) begin
            expect_word("hwint return pc", int'(STACK_TOP) - 1, word_t'(irq_at + 1));
            expect_word("hwint handler store", RES_BASE + 1, 32'h0000_4857);
            expect_word("status in hwint handler", RES_BASE + 2, 32'h0000_0020);
            expect_word("skipped main store", RES_BASE, fill_word(RES_BASE));
        end else begin
            expect_word("main store", RES_BASE, 32'h0000_6d61);
            expect_word("no hwint handler", RES_BASE + 1, fill_word(RES_BASE + 1));
            expect_word("no return pc", int'(STACK_TOP) - 1, fill_word(int'(STACK_TOP) - 1));
        end
        expect_word("stray handler", RES_BASE + 3, fill_word(RES_BASE + 3));
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles without finishing", MAX_CYCLES);
        $display("mismatches: %0d, other failures: %0d", mismatches, failures + 1);
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        start = 1'b0;
        hwint = 1'b0;
        load_req = 1'b0;
        alu_ops_test();
        cond_exec_test();
        stack_test();
        trap_test();
        hwint_test(1'b0);
        hwint_test(1'b1);
        $display("mismatches: %0d, other failures: %0d", mismatches, failures);
        if (mismatches + failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
cpu_pkg.sv
alu.sv
datapath.sv
cu.sv
cpu_top.sv
cpu_assert.sv
tb_cpu.sv

// File: Makefile
TOP = tb_cpu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^All checks passed$$"

clean:
	rm -rf obj_dir
